// ==== cache.f ====
rtl/cache_pkg.sv
rtl/cache_datapath.sv
rtl/cache_controller.sv
rtl/main_memory.sv
rtl/cache_top.sv
test/cache_sva.sv
test/cache_checker.sv
test/cache_tb.sv

// ==== rtl/cache_controller.sv ====
module cache_controller
    import cache_pkg::*;
(
    input  logic clk,
    input  logic reset,
    // CPU side
    input  logic cpu_req,
    input  logic cpu_we,
    input  logic flush_req,
    output logic cpu_ready,
    // Datapath status
    input  logic cache_hit,
    input  logic dirty,
    input  logic flush_done,
    // Datapath selects
    output logic index_sel,
    output logic data_sel,
    output sel_t valid_sel,
    output sel_t dirty_sel,
    output logic rd_en,
    output logic wr_en,
    output logic count_en,
    output logic count_clear,
    output logic flush_sel,
    output logic valid_clear,
    // Memory side
    input  logic mem_ready,
    output logic mem_rd,
    output logic mem_wr
);
    ctrl_state_t state;
    ctrl_state_t state_next;
    logic        flush_end_q;                    // Cycle of flush_ack
    logic        start_ok;

    // Requests are still held during a done pulse, so they are ignored then
    assign start_ok = !cpu_ready && !flush_end_q;

    always_ff @(posedge clk or negedge reset)
    begin
        if (!reset)
        begin
            state       <= IDLE;
            cpu_ready   <= 1'b0;
            flush_end_q <= 1'b0;
        end
        else
        begin
            state       <= state_next;
            cpu_ready   <= (state == COMPARE) && cache_hit;
            flush_end_q <= (state == FLUSH_DONE);
        end
    end

    always_comb
    begin
        state_next  = state;
        index_sel   = 1'b0;
        data_sel    = 1'b0;
        valid_sel   = SEL_KEEP;
        dirty_sel   = SEL_KEEP;
        rd_en       = 1'b0;
        wr_en       = 1'b0;
        count_en    = 1'b0;
        count_clear = 1'b0;
        flush_sel   = 1'b0;
        valid_clear = 1'b0;
        mem_rd      = 1'b0;
        mem_wr      = 1'b0;

        case (state)
            IDLE:
            begin
                if (start_ok && flush_req)
                begin
                    count_en    = 1'b1;          // Restart sweep at line 0
                    count_clear = 1'b1;
                    state_next  = FLUSH_SCAN;
                end
                else if (start_ok && cpu_req)
                    state_next = COMPARE;
            end

            COMPARE:
            begin
                if (cache_hit)
                begin
                    if (cpu_we)
                    begin
                        wr_en     = 1'b1;
                        dirty_sel = SEL_SET;
                    end
                    else
                        rd_en = 1'b1;
                    state_next = IDLE;
                end
                // Memory strobe starts here to save a cycle on the miss
                else if (dirty)
                begin
                    mem_wr     = 1'b1;
                    state_next = WRITE_BACK;
                end
                else
                begin
                    mem_rd     = 1'b1;
                    state_next = ALLOCATE;
                end
            end

            WRITE_BACK:
            begin
                mem_wr = 1'b1;                   // Victim from stored tag
                if (mem_ready)
                    state_next = ALLOCATE;
            end

            ALLOCATE:
            begin
                mem_rd = 1'b1;
                if (mem_ready)
                begin
                    wr_en      = 1'b1;
                    data_sel   = 1'b1;
                    valid_sel  = SEL_SET;
                    dirty_sel  = SEL_CLEAR;
                    state_next = COMPARE;        // Finishes as a hit
                end
            end

            FLUSH_SCAN:
            begin
                index_sel = 1'b1;
                if (flush_done)
                    state_next = FLUSH_DONE;
                else if (dirty)
                    state_next = FLUSH_WB;
                else
                    count_en = 1'b1;             // Clean line, skip
            end

            FLUSH_WB:
            begin
                index_sel = 1'b1;
                mem_wr    = 1'b1;
                if (mem_ready)
                begin
                    dirty_sel  = SEL_CLEAR;
                    count_en   = 1'b1;
                    state_next = FLUSH_SCAN;
                end
            end

            FLUSH_DONE:
            begin
                valid_clear = 1'b1;
                flush_sel   = 1'b1;
                state_next  = IDLE;
            end

            default:
                state_next = IDLE;
        endcase
    end

endmodule

// ==== rtl/cache_datapath.sv ====
module cache_datapath
    import cache_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    // CPU side
    input  logic [31:0] cpu_addr,
    input  logic [31:0] cpu_wdata,
    output logic [31:0] cpu_rdata,
    // Controller side
    input  logic        index_sel,
    input  logic        data_sel,
    input  sel_t        valid_sel,
    input  sel_t        dirty_sel,
    input  logic        rd_en,
    input  logic        wr_en,
    input  logic        count_en,
    input  logic        count_clear,
    input  logic        flush_sel,
    input  logic        valid_clear,
    output logic        cache_hit,
    output logic        dirty,
    output logic        flush_done,
    output logic        flush,
    // Memory side
    input  logic [31:0] mem_rdata,
    output logic [31:0] mem_araddr,
    output logic [31:0] mem_awaddr,
    output logic [31:0] mem_wdata
);
    logic [31:0]          data_mem [NUM_LINES];   // One word per line
    logic [TAG_W-1:0]     tag_mem [NUM_LINES];
    logic [NUM_LINES-1:0] valid_bits;
    logic [NUM_LINES-1:0] dirty_bits;

    logic [INDEX_W:0]     count;                  // One bit wider to reach NUM_LINES
    logic [INDEX_W:0]     count_next;

    logic [TAG_W-1:0]     cpu_tag;
    logic [TAG_W-1:0]     stored_tag;
    logic [INDEX_W-1:0]   index;
    logic [31:0]          line_data;
    logic [31:0]          cache_wdata;
    logic                 valid;
    logic                 valid_next;
    logic                 dirty_next;

    assign cpu_tag    = cpu_addr[31:32-TAG_W];
    assign stored_tag = tag_mem[index];
    assign line_data  = data_mem[index];
    assign valid      = valid_bits[index];
    assign dirty      = dirty_bits[index];

    assign cache_hit  = valid && (stored_tag == cpu_tag);
    assign flush_done = (count == (INDEX_W + 1)'(NUM_LINES));

    // Refill reads the requested line, victims go back to where they came from
    assign mem_araddr = {cpu_tag, index, 2'b00};
    assign mem_awaddr = {stored_tag, index, 2'b00};
    assign mem_wdata  = line_data;

    // Index select
    always_comb
    begin
        if (index_sel)
            index = count[INDEX_W-1:0];          // Flush sweep
        else
            index = cpu_addr[INDEX_W+1:2];
    end

    // Data select
    always_comb
    begin
        if (data_sel)
            cache_wdata = mem_rdata;             // Refill
        else
            cache_wdata = cpu_wdata;
    end

    always_comb
    begin
        case (valid_sel)
            SEL_CLEAR: valid_next = 1'b0;
            SEL_SET:   valid_next = 1'b1;
            default:   valid_next = valid;
        endcase
    end

    always_comb
    begin
        case (dirty_sel)
            SEL_CLEAR: dirty_next = 1'b0;
            SEL_SET:   dirty_next = 1'b1;
            default:   dirty_next = dirty;
        endcase
    end

    assign count_next = count_clear ? '0 : count + 1'b1;

    always_ff @(posedge clk or negedge reset)
    begin
        if (!reset)
            count <= '0;
        else if (count_en)
            count <= count_next;
    end

    // Line status bits
    always_ff @(posedge clk or negedge reset)
    begin
        if (!reset)
        begin
            valid_bits <= '0;
            dirty_bits <= '0;
        end
        else
        begin
            if (valid_clear)
                valid_bits <= '0;                // End of flush, whole cache
            else
                valid_bits[index] <= valid_next;
            dirty_bits[index] <= dirty_next;
        end
    end

    // Registered flush select gives a one-cycle acknowledge
    always_ff @(posedge clk or negedge reset)
    begin
        if (!reset)
            flush <= 1'b0;
        else
            flush <= flush_sel;
    end

    // Read data held for the cycle of cpu_ready
    always_ff @(posedge clk)
    begin
        if (rd_en)
            cpu_rdata <= line_data;
    end

    // Array written mid-cycle so the next state already sees it
    always_ff @(negedge clk)
    begin
        if (wr_en)
        begin
            data_mem[index] <= cache_wdata;
            tag_mem[index]  <= cpu_tag;
        end
    end

endmodule

// ==== rtl/cache_pkg.sv ====
package cache_pkg;

    // Address split: tag | index | 2-bit word offset
    localparam int TAG_W     = 20;
    localparam int INDEX_W   = 10;
    localparam int NUM_LINES = 1 << INDEX_W;    // Also the flush sweep end value

    // Main memory model, a 64 KB window of words
    localparam int MEM_WORDS   = 16384;
    localparam int MEM_LATENCY = 3;             // Strobe to ready, in cycles

    // Controller states
    typedef enum logic [2:0] {
        IDLE,
        COMPARE,
        WRITE_BACK,
        ALLOCATE,
        FLUSH_SCAN,
        FLUSH_WB,
        FLUSH_DONE
    } ctrl_state_t;

    // Valid and dirty bit update selects
    typedef enum logic [1:0] {
        SEL_KEEP  = 2'b00,
        SEL_CLEAR = 2'b01,
        SEL_SET   = 2'b10
    } sel_t;

endpackage

// ==== rtl/cache_top.sv ====
module cache_top
    import cache_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        cpu_req,
    input  logic        cpu_we,
    input  logic [31:0] cpu_addr,
    input  logic [31:0] cpu_wdata,
    input  logic        flush_req,
    output logic [31:0] cpu_rdata,
    output logic        cpu_ready,
    output logic        flush_ack
);
    // Controller to datapath
    logic index_sel;
    logic data_sel;
    sel_t valid_sel;
    sel_t dirty_sel;
    logic rd_en;
    logic wr_en;
    logic count_en;
    logic count_clear;
    logic flush_sel;
    logic valid_clear;
    logic cache_hit;
    logic dirty;
    logic flush_done;

    // Memory bus
    logic        mem_rd;
    logic        mem_wr;
    logic        mem_ready;
    logic [31:0] mem_araddr;
    logic [31:0] mem_awaddr;
    logic [31:0] mem_wdata;
    logic [31:0] mem_rdata;

    cache_controller ctrl_i (
        .clk         (clk),
        .reset       (reset),
        .cpu_req     (cpu_req),
        .cpu_we      (cpu_we),
        .flush_req   (flush_req),
        .cpu_ready   (cpu_ready),
        .cache_hit   (cache_hit),
        .dirty       (dirty),
        .flush_done  (flush_done),
        .index_sel   (index_sel),
        .data_sel    (data_sel),
        .valid_sel   (valid_sel),
        .dirty_sel   (dirty_sel),
        .rd_en       (rd_en),
        .wr_en       (wr_en),
        .count_en    (count_en),
        .count_clear (count_clear),
        .flush_sel   (flush_sel),
        .valid_clear (valid_clear),
        .mem_ready   (mem_ready),
        .mem_rd      (mem_rd),
        .mem_wr      (mem_wr)
    );

    cache_datapath dp_i (
        .clk         (clk),
        .reset       (reset),
        .cpu_addr    (cpu_addr),
        .cpu_wdata   (cpu_wdata),
        .cpu_rdata   (cpu_rdata),
        .index_sel   (index_sel),
        .data_sel    (data_sel),
        .valid_sel   (valid_sel),
        .dirty_sel   (dirty_sel),
        .rd_en       (rd_en),
        .wr_en       (wr_en),
        .count_en    (count_en),
        .count_clear (count_clear),
        .flush_sel   (flush_sel),
        .valid_clear (valid_clear),
        .cache_hit   (cache_hit),
        .dirty       (dirty),
        .flush_done  (flush_done),
        .flush       (flush_ack),
        .mem_rdata   (mem_rdata),
        .mem_araddr  (mem_araddr),
        .mem_awaddr  (mem_awaddr),
        .mem_wdata   (mem_wdata)
    );

    main_memory mem_i (
        .clk         (clk),
        .reset       (reset),
        .mem_rd      (mem_rd),
        .mem_wr      (mem_wr),
        .mem_araddr  (mem_araddr),
        .mem_awaddr  (mem_awaddr),
        .mem_wdata   (mem_wdata),
        .mem_rdata   (mem_rdata),
        .mem_ready   (mem_ready)
    );

endmodule

// ==== rtl/main_memory.sv ====
module main_memory
    import cache_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        mem_rd,
    input  logic        mem_wr,
    input  logic [31:0] mem_araddr,
    input  logic [31:0] mem_awaddr,
    input  logic [31:0] mem_wdata,
    output logic [31:0] mem_rdata,
    output logic        mem_ready
);
    logic [31:0] mem [MEM_WORDS];
    logic [$clog2(MEM_LATENCY + 1)-1:0] lat_cnt;
    logic        access;
    logic        last_cycle;

    // Each word starts out holding its own byte address
    initial
    begin
        for (int i = 0; i < MEM_WORDS; i++)
            mem[i] = 32'(i * 4);
    end

    assign access     = (mem_rd || mem_wr) && !mem_ready;
    assign last_cycle = access && (lat_cnt == $bits(lat_cnt)'(MEM_LATENCY - 1));

    always_ff @(posedge clk or negedge reset)
    begin
        if (!reset)
        begin
            lat_cnt   <= '0;
            mem_ready <= 1'b0;
        end
        else
        begin
            mem_ready <= last_cycle;
            if (access && !last_cycle)
                lat_cnt <= lat_cnt + 1'b1;
            else
                lat_cnt <= '0;                   // Idle, or access completing
        end
    end

    always @(posedge clk)
    begin
        if (last_cycle && mem_wr)
            mem[mem_awaddr[15:2]] <= mem_wdata;
        if (last_cycle && mem_rd)
            mem_rdata <= mem[mem_araddr[15:2]];  // Valid with mem_ready
    end

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
# Build with Verilator and run; the log decides the result
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module cache_tb -f cache.f -o cache_sim \
    && ./obj_dir/cache_sim +verilator+error+limit+100 | tee sim.log \
    || echo "Build or simulation run failed"
grep -q "^PASS: all tests$" sim.log 2>/dev/null && echo "Simulation passed" && exit 0 \
    || { echo "Simulation failed"; exit 1; }

// ==== test/cache_checker.sv ====
module cache_checker
    import cache_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        cpu_req,
    input  logic        cpu_we,
    input  logic [31:0] cpu_addr,
    input  logic [31:0] cpu_wdata,
    input  logic [31:0] cpu_rdata,
    input  logic        cpu_ready,
    input  logic        flush_req,
    input  logic        flush_ack,
    input  logic        exp_check,
    input  logic [31:0] exp_data,
    output int          data_errors,
    output int          proto_errors
);
    // Every line dirty, one scan cycle plus a write-back each
    localparam int FLUSH_LIMIT = NUM_LINES * (MEM_LATENCY + 2) + 64;
    // Request seen in IDLE to cpu_ready, for a line that is invalid and clean
    localparam int CLEAN_MISS_CYCLES = 2 + MEM_LATENCY + 1;

    logic [31:0] ref_mem [MEM_WORDS];
    int          flush_wait;
    int          req_cycles;
    logic        after_flush;

    // Memory content at power-up is the word's own byte address
    initial
    begin
        for (int i = 0; i < MEM_WORDS; i++)
            ref_mem[i] = 32'(i * 4);
    end

    always @(posedge clk)
    begin
        if (!reset)
        begin
            data_errors  = 0;
            proto_errors = 0;
            flush_wait   = 0;
            req_cycles   = 0;
            after_flush  = 1'b0;
        end
        else
        begin
            // A flush leaves every line invalid, so the next request must refill
            if (cpu_ready)
            begin
                if (after_flush && req_cycles != CLEAN_MISS_CYCLES)
                begin
                    proto_errors++;
                    $display("CHECK FAILED at %0t: cpu_ready latency expected %0d actual %0d",
                             $time, CLEAN_MISS_CYCLES, req_cycles);
                end
                after_flush = 1'b0;
                req_cycles  = 0;
            end
            else if (cpu_req)
                req_cycles++;

            if (cpu_ready && !cpu_req)
            begin
                proto_errors++;
                $display("Error at %0t: cpu_ready pulsed with no request pending", $time);
            end
            else if (cpu_ready && cpu_we)
                ref_mem[cpu_addr[15:2]] = cpu_wdata;    // Write completes here
            else if (cpu_ready)
            begin
                if (cpu_rdata !== ref_mem[cpu_addr[15:2]])
                begin
                    data_errors++;
                    $display("CHECK FAILED at %0t: cpu_rdata addr %h expected %h actual %h",
                             $time, cpu_addr, ref_mem[cpu_addr[15:2]], cpu_rdata);
                end
                if (exp_check && cpu_rdata !== exp_data)
                begin
                    data_errors++;
                    $display("CHECK FAILED at %0t: cpu_rdata (table) expected %h actual %h",
                             $time, exp_data, cpu_rdata);
                end
            end

            if (flush_ack && !flush_req)
            begin
                proto_errors++;
                $display("Error at %0t: flush_ack pulsed with no flush requested", $time);
            end

            if (flush_ack)
                after_flush = 1'b1;

            // Flush must end within one full sweep
            if (flush_req && !flush_ack)
            begin
                flush_wait++;
                if (flush_wait == FLUSH_LIMIT)
                begin
                    proto_errors++;
                    $display("Error at %0t: flush not acknowledged after %0d cycles",
                             $time, FLUSH_LIMIT);
                end
            end
            else
                flush_wait = 0;
        end
    end

endmodule

// ==== test/cache_sva.sv ====
module cache_sva
(
    input logic clk,
    input logic reset,
    input logic cpu_ready,
    input logic mem_rd,
    input logic mem_wr,
    input logic wr_en,
    input logic count_clear
);
    int fail_count = 0;    // Read by the testbench summary

    ready_pulse: assert property (@(posedge clk) disable iff (!reset)
        cpu_ready |=> !cpu_ready)
    else
    begin
        fail_count++;
        $error("cpu_ready held high for more than one cycle");
    end

    // One memory access at a time
    mem_exclusive: assert property (@(posedge clk) disable iff (!reset)
        !(mem_rd && mem_wr))
    else
    begin
        fail_count++;
        $error("mem_rd and mem_wr high together");
    end

    write_vs_clear: assert property (@(posedge clk) disable iff (!reset)
        !(wr_en && count_clear))
    else
    begin
        fail_count++;
        $error("wr_en high while the flush counter is cleared");
    end

endmodule

// ==== test/cache_tb.sv ====
module cache_tb
    import cache_pkg::*;
();
    localparam int RESET_CYCLES = 16;
    localparam int NUM_DIRECTED = 18;
    localparam int NUM_RANDOM   = 48;
    localparam int NUM_OPS      = NUM_DIRECTED + NUM_RANDOM + 1;   // Closing flush last
    localparam int MISS_CYCLES  = 2 + 2 * (MEM_LATENCY + 1) + 4;   // Dirty miss plus driving
    localparam int FLUSH_CYCLES = NUM_LINES * (MEM_LATENCY + 2) + 8;

    typedef enum logic [1:0] {OP_READ, OP_WRITE, OP_FLUSH} op_kind_t;

    typedef struct packed {
        op_kind_t    kind;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic        check;    // Compare against exp as well
        logic [31:0] exp;
    } op_t;

    logic        clk = 1'b0;
    logic        reset;
    logic        cpu_req;
    logic        cpu_we;
    logic [31:0] cpu_addr;
    logic [31:0] cpu_wdata;
    logic        flush_req;
    logic [31:0] cpu_rdata;
    logic        cpu_ready;
    logic        flush_ack;
    logic        exp_check;
    logic [31:0] exp_data;
    int          data_errors;
    int          proto_errors;

    op_t         ops [NUM_OPS];
    int          seed = 70;
    logic [31:0] rnd;
    logic        table_ready = 1'b0;
    int          flush_count;
    int          limit;
    int          total;

    always #4 clk = ~clk;

    cache_top dut_i (
        .clk       (clk),
        .reset     (reset),
        .cpu_req   (cpu_req),
        .cpu_we    (cpu_we),
        .cpu_addr  (cpu_addr),
        .cpu_wdata (cpu_wdata),
        .flush_req (flush_req),
        .cpu_rdata (cpu_rdata),
        .cpu_ready (cpu_ready),
        .flush_ack (flush_ack)
    );

    cache_checker check_i (
        .clk          (clk),
        .reset        (reset),
        .cpu_req      (cpu_req),
        .cpu_we       (cpu_we),
        .cpu_addr     (cpu_addr),
        .cpu_wdata    (cpu_wdata),
        .cpu_rdata    (cpu_rdata),
        .cpu_ready    (cpu_ready),
        .flush_req    (flush_req),
        .flush_ack    (flush_ack),
        .exp_check    (exp_check),
        .exp_data     (exp_data),
        .data_errors  (data_errors),
        .proto_errors (proto_errors)
    );

    bind cache_controller cache_sva sva_i (
        .clk         (clk),
        .reset       (reset),
        .cpu_ready   (cpu_ready),
        .mem_rd      (mem_rd),
        .mem_wr      (mem_wr),
        .wr_en       (wr_en),
        .count_clear (count_clear)
    );

    task automatic set_op(input int idx, input op_kind_t kind, input logic [31:0] addr,
                          input logic [31:0] wdata, input logic check, input logic [31:0] exp);
        ops[idx] = '{kind, addr, wdata, check, exp};
    endtask

    task automatic build_table();
        set_op(0,  OP_READ,  32'h0000_0040, 32'h0, 1'b1, 32'h0000_0040);    // Cold miss
        set_op(1,  OP_READ,  32'h0000_0040, 32'h0, 1'b1, 32'h0000_0040);    // Now a hit
        set_op(2,  OP_WRITE, 32'h0000_0100, 32'hCAFE_0001, 1'b0, 32'h0);
        set_op(3,  OP_READ,  32'h0000_0100, 32'h0, 1'b1, 32'hCAFE_0001);
        set_op(4,  OP_WRITE, 32'h0000_0010, 32'h1234_5678, 1'b0, 32'h0);
        set_op(5,  OP_READ,  32'h0000_1010, 32'h0, 1'b1, 32'h0000_1010);    // Evicts dirty line
        set_op(6,  OP_READ,  32'h0000_0010, 32'h0, 1'b1, 32'h1234_5678);
        set_op(7,  OP_WRITE, 32'h0000_2000, 32'hA000_0001, 1'b0, 32'h0);
        set_op(8,  OP_WRITE, 32'h0000_2004, 32'hA000_0002, 1'b0, 32'h0);
        set_op(9,  OP_WRITE, 32'h0000_2008, 32'hA000_0003, 1'b0, 32'h0);
        set_op(10, OP_WRITE, 32'h0000_3FFC, 32'hA000_0004, 1'b0, 32'h0);    // Last line
        set_op(11, OP_FLUSH, 32'h0, 32'h0, 1'b0, 32'h0);
        set_op(12, OP_READ,  32'h0000_2000, 32'h0, 1'b1, 32'hA000_0001);
        set_op(13, OP_READ,  32'h0000_2004, 32'h0, 1'b1, 32'hA000_0002);
        set_op(14, OP_READ,  32'h0000_2008, 32'h0, 1'b1, 32'hA000_0003);
        set_op(15, OP_READ,  32'h0000_3FFC, 32'h0, 1'b1, 32'hA000_0004);
        set_op(16, OP_READ,  32'h0000_0100, 32'h0, 1'b1, 32'hCAFE_0001);
        set_op(17, OP_READ,  32'h0000_FFFC, 32'h0, 1'b1, 32'h0000_FFFC);    // Top of window
        // Few indices and many tags, so evictions are frequent
        for (int i = NUM_DIRECTED; i < NUM_OPS - 1; i++)
        begin
            rnd = $random(seed);
            set_op(i, rnd[0] ? OP_WRITE : OP_READ, rnd & 32'h0000_F03C,
                   32'($random(seed)), 1'b0, 32'h0);
        end
        set_op(NUM_OPS - 1, OP_FLUSH, 32'h0, 32'h0, 1'b0, 32'h0);
    endtask

    // Hold the request until its done pulse, then release it
    task automatic apply_op(input op_t op);
        @(negedge clk);
        exp_check = op.check;
        exp_data  = op.exp;
        if (op.kind == OP_FLUSH)
            flush_req = 1'b1;
        else
        begin
            cpu_req   = 1'b1;
            cpu_we    = (op.kind == OP_WRITE);
            cpu_addr  = op.addr;
            cpu_wdata = op.wdata;
        end
        do
            @(posedge clk);
        while (!(cpu_ready || flush_ack));
        @(negedge clk);
        cpu_req   = 1'b0;
        cpu_we    = 1'b0;
        flush_req = 1'b0;
        exp_check = 1'b0;
    endtask

    task automatic report_counts();
        $display("Error counts: data %0d, protocol %0d, assertion %0d",
                 data_errors, proto_errors, dut_i.ctrl_i.sva_i.fail_count);
    endtask

    initial
    begin
        reset     = 1'b0;
        cpu_req   = 1'b0;
        cpu_we    = 1'b0;
        cpu_addr  = '0;
        cpu_wdata = '0;
        flush_req = 1'b0;
        exp_check = 1'b0;
        exp_data  = '0;
        build_table();
        table_ready = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset = 1'b1;

        for (int i = 0; i < NUM_OPS; i++)
            apply_op(ops[i]);

        repeat (2) @(posedge clk);
        report_counts();
        total = data_errors + proto_errors + dut_i.ctrl_i.sva_i.fail_count;
        if (total == 0)
            $display("PASS: all tests");
        else
            $display("FAIL: see errors above");
        $finish;
    end

    // Watchdog sized from the table
    initial
    begin
        wait (table_ready);
        flush_count = 0;
        for (int i = 0; i < NUM_OPS; i++)
            if (ops[i].kind == OP_FLUSH)
                flush_count++;
        limit = RESET_CYCLES + NUM_OPS * MISS_CYCLES + flush_count * FLUSH_CYCLES + 200;
        repeat (limit) @(posedge clk);
        $display("Timeout: operations not finished after %0d cycles", limit);
        report_counts();
        $display("FAIL: see errors above");
        $finish;
    end

endmodule
